/* verilog/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] word_t;
    typedef logic [ 4:0] reg_idx_t;
    typedef logic [ 6:0] opcode_t;
    typedef logic [ 2:0] funct3_t;
    typedef logic [16:0] alu_op_t;
    typedef logic [ 2:0] mem_size_t;     // {word, half, byte}.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Major opcodes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam opcode_t OPC_OP     = 7'h33;
    localparam opcode_t OPC_OP_IMM = 7'h13;
    localparam opcode_t OPC_LOAD   = 7'h03;
    localparam opcode_t OPC_STORE  = 7'h23;
    localparam opcode_t OPC_BRANCH = 7'h63;
    localparam opcode_t OPC_JAL    = 7'h6f;
    localparam opcode_t OPC_JALR   = 7'h67;
    localparam opcode_t OPC_LUI    = 7'h37;
    localparam opcode_t OPC_AUIPC  = 7'h17;

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;     // sub and arithmetic shifts.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU one-hot bit positions.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_OR   = 5;
    localparam int ALU_XOR  = 6;
    localparam int ALU_SLL  = 7;
    localparam int ALU_SRL  = 8;
    localparam int ALU_SRA  = 9;
    localparam int ALU_LUI  = 10;
    localparam int ALU_BNE  = 11;
    localparam int ALU_BEQ  = 12;
    localparam int ALU_BGE  = 13;
    localparam int ALU_BGEU = 14;
    localparam int ALU_BLT  = 15;
    localparam int ALU_BLTU = 16;

    typedef enum logic [5:0] {
        INS_ILLEGAL,
        INS_ADD, INS_SUB, INS_SLL, INS_SLT, INS_SLTU,
        INS_XOR, INS_SRL, INS_SRA, INS_OR, INS_AND,
        INS_ADDI, INS_SLTI, INS_SLTIU, INS_XORI, INS_ORI,
        INS_ANDI, INS_SLLI, INS_SRLI, INS_SRAI,
        INS_LB, INS_LH, INS_LW, INS_LBU, INS_LHU,
        INS_SB, INS_SH, INS_SW,
        INS_BEQ, INS_BNE, INS_BLT, INS_BGE, INS_BLTU, INS_BGEU,
        INS_JAL, INS_JALR, INS_LUI, INS_AUIPC
    } instr_e;

    typedef enum logic [2:0] {
        FMT_NONE, FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J
    } fmt_e;

endpackage

`default_nettype wire

/* verilog/decode_stage_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage_reg
    import rv_decode_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    input  word_t in_inst,
    input  word_t in_pc,
    input  logic  out_ready,
    output logic  in_ready,
    output logic  out_valid,
    output word_t held_inst,
    output word_t held_pc
);

    typedef enum logic {
        EMPTY,
        FULL
    } state_e;

    state_e state;
    state_e next_state;
    logic   accept;

    // Refill on the same edge the held entry drains.
    assign in_ready  = (state == EMPTY) || out_ready;
    assign accept    = in_valid && in_ready;
    assign out_valid = (state == FULL);

    always_comb begin
        next_state = state;
        case (state)
            EMPTY: begin
                if (accept) begin
                    next_state = FULL;
                end
            end
            FULL: begin
                if (out_ready && !accept) begin
                    next_state = EMPTY;     // Drained, nothing new.
                end
            end
            default: next_state = EMPTY;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= EMPTY;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_inst <= in_inst;
            held_pc   <= in_pc;
        end
    end

endmodule

`default_nettype wire

/* verilog/instr_match.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_match
    import rv_decode_pkg::*;
(
    input  word_t  inst,
    output instr_e instr_id,
    output fmt_e   fmt
);

    opcode_t    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign funct6 = inst[31:26];    // Bit 25 is shamt[5] on RV64.

    always_comb begin
        instr_id = INS_ILLEGAL;
        fmt      = FMT_NONE;
        case (opcode)
            OPC_OP: begin
                fmt = FMT_R;
                case (funct3)
                    3'h0: begin
                        if (funct7 == F7_BASE) instr_id = INS_ADD;
                        else if (funct7 == F7_ALT) instr_id = INS_SUB;
                    end
                    3'h1: if (funct7 == F7_BASE) instr_id = INS_SLL;
                    3'h2: if (funct7 == F7_BASE) instr_id = INS_SLT;
                    3'h3: if (funct7 == F7_BASE) instr_id = INS_SLTU;
                    3'h4: if (funct7 == F7_BASE) instr_id = INS_XOR;
                    3'h5: begin
                        if (funct7 == F7_BASE) instr_id = INS_SRL;
                        else if (funct7 == F7_ALT) instr_id = INS_SRA;
                    end
                    3'h6: if (funct7 == F7_BASE) instr_id = INS_OR;
                    default: if (funct7 == F7_BASE) instr_id = INS_AND;
                endcase
            end
            OPC_OP_IMM: begin
                fmt = FMT_I;
                case (funct3)
                    3'h0: instr_id = INS_ADDI;
                    3'h1: if (funct6 == F7_BASE[6:1]) instr_id = INS_SLLI;
                    3'h2: instr_id = INS_SLTI;
                    3'h3: instr_id = INS_SLTIU;
                    3'h4: instr_id = INS_XORI;
                    3'h5: begin
                        if (funct6 == F7_BASE[6:1]) instr_id = INS_SRLI;
                        else if (funct6 == F7_ALT[6:1]) instr_id = INS_SRAI;
                    end
                    3'h6: instr_id = INS_ORI;
                    default: instr_id = INS_ANDI;
                endcase
            end
            OPC_LOAD: begin
                fmt = FMT_I;
                case (funct3)
                    3'h0: instr_id = INS_LB;
                    3'h1: instr_id = INS_LH;
                    3'h2: instr_id = INS_LW;
                    3'h4: instr_id = INS_LBU;
                    3'h5: instr_id = INS_LHU;
                    default: instr_id = INS_ILLEGAL;
                endcase
            end
            OPC_STORE: begin
                fmt = FMT_S;
                case (funct3)
                    3'h0: instr_id = INS_SB;
                    3'h1: instr_id = INS_SH;
                    3'h2: instr_id = INS_SW;
                    default: instr_id = INS_ILLEGAL;
                endcase
            end
            OPC_BRANCH: begin
                fmt = FMT_B;
                case (funct3)
                    3'h0: instr_id = INS_BEQ;
                    3'h1: instr_id = INS_BNE;
                    3'h4: instr_id = INS_BLT;
                    3'h5: instr_id = INS_BGE;
                    3'h6: instr_id = INS_BLTU;
                    3'h7: instr_id = INS_BGEU;
                    default: instr_id = INS_ILLEGAL;
                endcase
            end
            OPC_JALR: begin
                fmt = FMT_I;
                if (funct3 == 3'h0) instr_id = INS_JALR;
            end
            OPC_JAL: begin
                fmt      = FMT_J;
                instr_id = INS_JAL;
            end
            OPC_LUI: begin
                fmt      = FMT_U;
                instr_id = INS_LUI;
            end
            OPC_AUIPC: begin
                fmt      = FMT_U;
                instr_id = INS_AUIPC;
            end
            default: instr_id = INS_ILLEGAL;    // CSR, fence, system.
        endcase
        if (instr_id == INS_ILLEGAL) begin
            fmt = FMT_NONE;
        end
    end

endmodule

`default_nettype wire

/* verilog/control_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module control_gen
    import rv_decode_pkg::*;
(
    input  instr_e    instr_id,
    output alu_op_t   alu_op,
    output logic      gpr_we,
    output logic      src1_is_pc,
    output logic      src2_is_imm,
    output logic      is_jump,
    output logic      is_branch,
    output logic      is_load,
    output logic      is_store,
    output mem_size_t mem_size,
    output logic      load_sext,
    output logic      illegal
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU operation.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        alu_op = '0;
        case (instr_id)
            INS_ADD, INS_ADDI, INS_AUIPC, INS_JAL, INS_JALR,
            INS_LB, INS_LH, INS_LW, INS_LBU, INS_LHU,
            INS_SB, INS_SH, INS_SW:  alu_op[ALU_ADD]  = 1'b1;    // Address or sum.
            INS_SUB:                 alu_op[ALU_SUB]  = 1'b1;
            INS_SLT, INS_SLTI:       alu_op[ALU_SLT]  = 1'b1;
            INS_SLTU, INS_SLTIU:     alu_op[ALU_SLTU] = 1'b1;
            INS_AND, INS_ANDI:       alu_op[ALU_AND]  = 1'b1;
            INS_OR, INS_ORI:         alu_op[ALU_OR]   = 1'b1;
            INS_XOR, INS_XORI:       alu_op[ALU_XOR]  = 1'b1;
            INS_SLL, INS_SLLI:       alu_op[ALU_SLL]  = 1'b1;
            INS_SRL, INS_SRLI:       alu_op[ALU_SRL]  = 1'b1;
            INS_SRA, INS_SRAI:       alu_op[ALU_SRA]  = 1'b1;
            INS_LUI:                 alu_op[ALU_LUI]  = 1'b1;
            INS_BNE:                 alu_op[ALU_BNE]  = 1'b1;
            INS_BEQ:                 alu_op[ALU_BEQ]  = 1'b1;
            INS_BGE:                 alu_op[ALU_BGE]  = 1'b1;
            INS_BGEU:                alu_op[ALU_BGEU] = 1'b1;
            INS_BLT:                 alu_op[ALU_BLT]  = 1'b1;
            INS_BLTU:                alu_op[ALU_BLTU] = 1'b1;
            default:                 alu_op = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Class flags and memory access.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign is_load  = instr_id inside {INS_LB, INS_LH, INS_LW, INS_LBU, INS_LHU};
    assign is_store = instr_id inside {INS_SB, INS_SH, INS_SW};
    assign is_branch = instr_id inside {INS_BEQ, INS_BNE, INS_BLT,
                                        INS_BGE, INS_BLTU, INS_BGEU};
    assign illegal  = (instr_id == INS_ILLEGAL);

    assign gpr_we      = !illegal && !is_store && !is_branch;
    assign is_jump     = is_branch || (instr_id == INS_JAL) || (instr_id == INS_JALR);
    assign src1_is_pc  = is_branch || (instr_id == INS_JAL) || (instr_id == INS_AUIPC);
    assign load_sext   = (instr_id == INS_LB) || (instr_id == INS_LH);

    // Everything but R-format takes an immediate.
    assign src2_is_imm = !illegal && !(instr_id inside {INS_ADD, INS_SUB, INS_SLL,
                                                        INS_SLT, INS_SLTU, INS_XOR,
                                                        INS_SRL, INS_SRA, INS_OR,
                                                        INS_AND});

    always_comb begin
        case (instr_id)
            INS_LW, INS_SW:          mem_size = 3'b100;
            INS_LH, INS_LHU, INS_SH: mem_size = 3'b010;
            INS_LB, INS_LBU, INS_SB: mem_size = 3'b001;
            default:                 mem_size = 3'b000;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/operand_fields.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_fields
    import rv_decode_pkg::*;
(
    input  word_t    inst,
    input  fmt_e     fmt,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (fmt)
            FMT_I:   imm = imm_i;
            FMT_S:   imm = imm_s;
            FMT_B:   imm = imm_b;
            FMT_U:   imm = imm_u;
            FMT_J:   imm = imm_j;
            default: imm = '0;      // R and none.
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv_decode_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode_top
    import rv_decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  word_t     in_inst,
    input  word_t     in_pc,
    input  logic      out_ready,
    output logic      in_ready,
    output logic      out_valid,
    output word_t     out_pc,
    output reg_idx_t  rs1,
    output reg_idx_t  rs2,
    output reg_idx_t  rd,
    output word_t     imm,
    output alu_op_t   alu_op,
    output logic      gpr_we,
    output logic      src1_is_pc,
    output logic      src2_is_imm,
    output logic      is_jump,
    output logic      is_branch,
    output logic      is_load,
    output logic      is_store,
    output mem_size_t mem_size,
    output logic      load_sext,
    output logic      illegal
);

    word_t  held_inst;
    instr_e instr_id;
    fmt_e   fmt;

    decode_stage_reg i_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_inst   (in_inst),
        .in_pc     (in_pc),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .held_inst (held_inst),
        .held_pc   (out_pc)
    );

    instr_match i_match (
        .inst     (held_inst),
        .instr_id (instr_id),
        .fmt      (fmt)
    );

    control_gen i_ctrl (
        .instr_id    (instr_id),
        .alu_op      (alu_op),
        .gpr_we      (gpr_we),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .is_jump     (is_jump),
        .is_branch   (is_branch),
        .is_load     (is_load),
        .is_store    (is_store),
        .mem_size    (mem_size),
        .load_sext   (load_sext),
        .illegal     (illegal)
    );

    operand_fields i_fields (
        .inst (held_inst),
        .fmt  (fmt),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .imm  (imm)
    );

endmodule

`default_nettype wire

/* bench/rv_decode_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode_checker
    import rv_decode_pkg::*;
(
    input wire logic      clk,
    input wire logic      rst,
    input wire logic      in_valid,
    input wire logic      in_ready,
    input wire logic      out_valid,
    input wire logic      out_ready,
    input wire word_t     out_pc,
    input wire reg_idx_t  rs1,
    input wire reg_idx_t  rs2,
    input wire reg_idx_t  rd,
    input wire word_t     imm,
    input wire alu_op_t   alu_op,
    input wire logic      gpr_we,
    input wire logic      src1_is_pc,
    input wire logic      src2_is_imm,
    input wire logic      is_jump,
    input wire logic      is_branch,
    input wire logic      is_load,
    input wire logic      is_store,
    input wire mem_size_t mem_size,
    input wire logic      load_sext,
    input wire logic      illegal
);

    logic [107:0] out_bus;
    logic         occupied;     // Stage holds an instruction.

    assign out_bus = {out_pc, rs1, rs2, rd, imm, alu_op, gpr_we, src1_is_pc,
                      src2_is_imm, is_jump, is_branch, is_load, is_store,
                      mem_size, load_sext, illegal};

    // Occupancy seen from the two handshakes alone.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occupied <= 1'b0;
        end else if (in_valid && in_ready) begin
            occupied <= 1'b1;
        end else if (occupied && out_ready) begin
            occupied <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake rules.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_bus))
        else $error("Outputs changed under back-pressure");

    a_valid_after_accept: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready |=> out_valid)
        else $error("out_valid low after an accept");

    a_ready_rule: assert property (@(posedge clk) disable iff (rst)
        in_ready == (!occupied || out_ready))
        else $error("in_ready does not follow stage occupancy");

endmodule

bind rv_decode_top rv_decode_checker i_checker (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_pc      (out_pc),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .imm         (imm),
    .alu_op      (alu_op),
    .gpr_we      (gpr_we),
    .src1_is_pc  (src1_is_pc),
    .src2_is_imm (src2_is_imm),
    .is_jump     (is_jump),
    .is_branch   (is_branch),
    .is_load     (is_load),
    .is_store    (is_store),
    .mem_size    (mem_size),
    .load_sext   (load_sext),
    .illegal     (illegal)
);

`default_nettype wire

/* bench/tb_rv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_decode
    import rv_decode_pkg::*;
;

    localparam int N_XFER = 400;
    localparam int PERIOD = 100;

    logic      clk = 1'b0;
    logic      rst;
    logic      in_valid;
    word_t     in_inst;
    word_t     in_pc;
    logic      out_ready;
    logic      in_ready;
    logic      out_valid;
    word_t     out_pc;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     imm;
    alu_op_t   alu_op;
    logic      gpr_we;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      is_jump;
    logic      is_branch;
    logic      is_load;
    logic      is_store;
    mem_size_t mem_size;
    logic      load_sext;
    logic      illegal;

    word_t     tmpl_word [0:63];
    word_t     tmpl_mask [0:63];
    int        n_kept;
    int        n_tmpl;
    word_t     inst_q [$];
    word_t     pc_q [$];
    int        sent;
    int        received;
    int        mismatches;
    int        other_errors;

    alu_op_t   exp_alu;
    word_t     exp_imm;
    mem_size_t exp_size;
    logic      exp_we, exp_s1pc, exp_s2imm, exp_jump, exp_branch;
    logic      exp_load, exp_store, exp_sext, exp_illegal;

    rv_decode_top i_dut (.*);

    always #(PERIOD / 2) clk = ~clk;

    task automatic add_tmpl(input word_t word, input word_t mask);
        tmpl_word[n_tmpl] = word;
        tmpl_mask[n_tmpl] = mask;
        n_tmpl++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Encoding table.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_table();
        word_t r_ops [10];
        word_t i_ops [6];
        word_t sh_ops [3];
        word_t ls_ops [8];
        word_t br_ops [6];
        r_ops  = '{32'h33, 32'h40000033, 32'h1033, 32'h2033, 32'h3033,
                   32'h4033, 32'h5033, 32'h40005033, 32'h6033, 32'h7033};
        i_ops  = '{32'h13, 32'h2013, 32'h3013, 32'h4013, 32'h6013, 32'h7013};
        sh_ops = '{32'h1013, 32'h5013, 32'h40005013};
        ls_ops = '{32'h03, 32'h1003, 32'h2003, 32'h4003, 32'h5003,
                   32'h23, 32'h1023, 32'h2023};
        br_ops = '{32'h63, 32'h1063, 32'h4063, 32'h5063, 32'h6063, 32'h7063};
        n_tmpl = 0;
        foreach (r_ops[i]) add_tmpl(r_ops[i], 32'hfe00707f);
        foreach (i_ops[i]) add_tmpl(i_ops[i], 32'h0000707f);
        foreach (sh_ops[i]) add_tmpl(sh_ops[i], 32'hfc00707f);
        foreach (ls_ops[i]) add_tmpl(ls_ops[i], 32'h0000707f);
        foreach (br_ops[i]) add_tmpl(br_ops[i], 32'h0000707f);
        add_tmpl(32'h67, 32'h707f);         // jalr.
        add_tmpl(32'h6f, 32'h7f);
        add_tmpl(32'h37, 32'h7f);
        add_tmpl(32'h17, 32'h7f);
        n_kept = n_tmpl;
        add_tmpl(32'h1073, 32'h707f);       // Dropped csrrw, ecall, ebreak, mret, fence.i and zero.
        add_tmpl(32'h00000073, '1);
        add_tmpl(32'h00100073, '1);
        add_tmpl(32'h30200073, '1);
        add_tmpl(32'h0000100f, '1);
        add_tmpl(32'h00000000, '1);
    endtask

    function automatic word_t gen_inst();
        int    pick;
        int    idx;
        word_t r;
        pick = $urandom % 10;
        r    = $urandom;
        if (pick == 0) return r;
        if (pick == 1) idx = n_kept + ($urandom % (n_tmpl - n_kept));
        else idx = $urandom % n_kept;
        return (r & ~tmpl_mask[idx]) | tmpl_word[idx];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic ref_decode(input word_t w);
        logic [2:0] f3;
        int         b;
        int         fmt;        // 0 none, 1 R, 2 I, 3 S, 4 B, 5 U, 6 J.
        word_t      sx;
        f3 = w[14:12];
        b = -1;
        fmt = 0;
        {exp_we, exp_s1pc, exp_s2imm, exp_jump, exp_branch} = '0;
        {exp_load, exp_store, exp_sext, exp_illegal} = '0;
        exp_alu = '0;
        exp_size = '0;
        case (w[6:0])
            7'h33: begin
                fmt = 1;
                case ({w[31:25], f3})
                    {7'h00, 3'd0}: b = ALU_ADD;
                    {7'h20, 3'd0}: b = ALU_SUB;
                    {7'h00, 3'd1}: b = ALU_SLL;
                    {7'h00, 3'd2}: b = ALU_SLT;
                    {7'h00, 3'd3}: b = ALU_SLTU;
                    {7'h00, 3'd4}: b = ALU_XOR;
                    {7'h00, 3'd5}: b = ALU_SRL;
                    {7'h20, 3'd5}: b = ALU_SRA;
                    {7'h00, 3'd6}: b = ALU_OR;
                    {7'h00, 3'd7}: b = ALU_AND;
                    default: b = -1;
                endcase
            end
            7'h13: begin
                fmt = 2;
                case (f3)
                    3'd0: b = ALU_ADD;
                    3'd1: b = (w[31:26] == 6'h00) ? ALU_SLL : -1;
                    3'd2: b = ALU_SLT;
                    3'd3: b = ALU_SLTU;
                    3'd4: b = ALU_XOR;
                    3'd5: b = (w[31:26] == 6'h00) ? ALU_SRL : (w[31:26] == 6'h10) ? ALU_SRA : -1;
                    3'd6: b = ALU_OR;
                    default: b = ALU_AND;
                endcase
            end
            7'h03: begin
                fmt = 2;
                if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
                    b = ALU_ADD;
                    exp_load = 1'b1;
                    exp_size = 3'b001 << f3[1:0];
                    exp_sext = (f3 < 3'd2);
                end
            end
            7'h23: begin
                fmt = 3;
                if (f3 <= 3'd2) begin
                    b = ALU_ADD;
                    exp_store = 1'b1;
                    exp_size = 3'b001 << f3[1:0];
                end
            end
            7'h63: begin
                fmt = 4;
                exp_branch = !(f3 inside {3'd2, 3'd3});
                case (f3)
                    3'd0: b = ALU_BEQ;
                    3'd1: b = ALU_BNE;
                    3'd4: b = ALU_BLT;
                    3'd5: b = ALU_BGE;
                    3'd6: b = ALU_BLTU;
                    3'd7: b = ALU_BGEU;
                    default: b = -1;
                endcase
            end
            7'h67: begin
                fmt = 2;
                if (f3 == 3'd0) b = ALU_ADD;
                exp_jump = 1'b1;
            end
            7'h6f: begin
                fmt = 6;
                b = ALU_ADD;
                exp_jump = 1'b1;
                exp_s1pc = 1'b1;
            end
            7'h37: begin
                fmt = 5;
                b = ALU_LUI;
            end
            7'h17: begin
                fmt = 5;
                b = ALU_ADD;
                exp_s1pc = 1'b1;
            end
            default: b = -1;
        endcase
        if (b < 0) begin
            fmt = 0;
            {exp_s1pc, exp_jump, exp_branch, exp_load, exp_store, exp_sext} = '0;
            exp_size = '0;
            exp_illegal = 1'b1;
        end else begin
            exp_alu[b] = 1'b1;
            exp_we = !exp_store && !exp_branch;
            exp_s2imm = (fmt != 1);
            exp_s1pc = exp_s1pc || exp_branch;
            exp_jump = exp_jump || exp_branch;
        end
        sx = word_t'($signed(w) >>> 31);
        case (fmt)
            2: exp_imm = word_t'($signed(w) >>> 20);
            3: exp_imm = (sx << 12) | (w[31:25] << 5) | w[11:7];
            4: exp_imm = (sx << 12) | (w[7] << 11) | (w[30:25] << 5) | (w[11:8] << 1);
            5: exp_imm = w & 32'hfffff000;
            6: exp_imm = (sx << 20) | (w[19:12] << 12) | (w[20] << 11) | (w[30:21] << 1);
            default: exp_imm = '0;
        endcase
    endtask

    task automatic check_field(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scoreboard.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        word_t w;
        word_t p;
        if (!rst && out_valid && out_ready) begin
            if (inst_q.size() == 0) begin
                $display("Output transfer without any accepted instruction");
                other_errors++;
            end else begin
                w = inst_q.pop_front();
                p = pc_q.pop_front();
                ref_decode(w);
                check_field("out_pc", out_pc, p);
                check_field("rs1", rs1, w[19:15]);
                check_field("rs2", rs2, w[24:20]);
                check_field("rd", rd, w[11:7]);
                check_field("imm", imm, exp_imm);
                check_field("alu_op", alu_op, exp_alu);
                check_field("gpr_we", gpr_we, exp_we);
                check_field("src1_is_pc", src1_is_pc, exp_s1pc);
                check_field("src2_is_imm", src2_is_imm, exp_s2imm);
                check_field("is_jump", is_jump, exp_jump);
                check_field("is_branch", is_branch, exp_branch);
                check_field("is_load", is_load, exp_load);
                check_field("is_store", is_store, exp_store);
                check_field("mem_size", mem_size, exp_size);
                check_field("load_sext", load_sext, exp_sext);
                check_field("illegal", illegal, exp_illegal);
            end
            received++;
        end
        if (!rst && in_valid && in_ready) begin
            inst_q.push_back(in_inst);
            pc_q.push_back(in_pc);
        end
    end

    initial begin
        #(N_XFER * 20 * PERIOD + 50 * PERIOD);
        $display("Timeout: %0d of %0d transfers seen", received, N_XFER);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        word_t next_pc;
        logic  took;
        void'($urandom(32'ha0bf_ef36));
        build_table();
        {sent, received, mismatches, other_errors} = '0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_inst = '0;
        in_pc = '0;
        out_ready = 1'b0;
        next_pc = 32'h0000_1000;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        #1;
        assert (out_valid === 1'b0 && in_ready === 1'b1) else begin
            $display("Stage not empty and ready after reset");
            other_errors++;
        end
        while (sent < N_XFER) begin
            @(posedge clk);
            took = in_valid && in_ready;
            if (took) sent++;
            #10;
            if (!in_valid || took) begin
                in_valid = (sent < N_XFER) && ($urandom % 4 != 0);
                if (in_valid) begin
                    in_inst = gen_inst();
                    in_pc = next_pc;
                    next_pc += 4;
                end
            end
            out_ready = ($urandom % 4 != 0);
        end
        in_valid = 1'b0;
        out_ready = 1'b1;
        wait (received >= N_XFER);
        repeat (3) @(posedge clk);
        if (inst_q.size() != 0 || received != N_XFER) begin
            $display("Transfer count off: %0d sent, %0d received", sent, received);
            other_errors++;
        end
        $display("Errors: mismatch=%0d other=%0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
verilog/rv_decode_pkg.sv
verilog/decode_stage_reg.sv
verilog/instr_match.sv
verilog/control_gen.sv
verilog/operand_fields.sv
verilog/rv_decode_top.sv
bench/rv_decode_checker.sv
bench/tb_rv_decode.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing
TOP       = tb_rv_decode
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
